// ==== verilog/huff_mem_pkg.sv ====
package huff_mem_pkg;

    // external sram bus word and address

    typedef logic [31:0] word_t;   // one bus data word
    typedef logic [31:0] addr_t;   // byte address
    typedef logic [3:0]  sel_t;    // byte lanes

    // region bases inside the shared sram
    // histogram count for char c sits at base + 4*c
    localparam addr_t HIST_BASE_DEF = 32'h3300_0000;

    // codebook path for char c sits at base + 16*c, msw first
    localparam addr_t CB_BASE_DEF = 32'h3300_0C00;

endpackage

// ==== verilog/huff_sym_pkg.sv ====
package huff_sym_pkg;

    // symbol side types of the compressor

    typedef logic [7:0]   char_t;   // input character
    typedef logic [31:0]  count_t;  // histogram count, saturating
    typedef logic [127:0] path_t;   // huffman code path

    // words per stored path
    localparam int PATH_WORDS = 4;

endpackage

// ==== verilog/mem_req_if.sv ====
// one word request between a client block and the bus mux
// four-phase: req up, ack up, req down, ack down
interface mem_req_if;

    logic                req;
    logic                we;      // 1 = write, 0 = read
    huff_mem_pkg::addr_t addr;
    huff_mem_pkg::word_t wdata;
    huff_mem_pkg::word_t rdata;   // valid while ack is high
    logic                ack;

    modport client (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport server (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

// ==== verilog/histogram_port.sv ====
module histogram_port #(
    parameter huff_mem_pkg::addr_t HIST_BASE = huff_mem_pkg::HIST_BASE_DEF
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_i,
    input  huff_sym_pkg::char_t  char_i,
    output logic                 ack_o,
    output huff_sym_pkg::count_t count_o,
    mem_req_if.client            mem
);

    typedef enum logic [1:0] {
        H_IDLE,
        H_READ,
        H_WRITE,
        H_DONE
    } hist_state_t;

    hist_state_t          state;
    huff_sym_pkg::char_t  char_q;
    huff_sym_pkg::count_t count_q;   // incremented count, also the write data
    huff_sym_pkg::count_t count_inc;
    logic                 mem_req_q;

    // saturate at all ones
    always_comb begin
        if (mem.rdata == '1) begin
            count_inc = huff_sym_pkg::count_t'(mem.rdata);
        end else begin
            count_inc = huff_sym_pkg::count_t'(mem.rdata) + 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= H_IDLE;
            mem_req_q <= 1'b0;
            ack_o     <= 1'b0;
            count_q   <= '0;
        end else begin
            case (state)
                H_IDLE: begin
                    if (req_i) begin
                        mem_req_q <= 1'b1;   // read request next cycle
                        state     <= H_READ;
                    end
                end
                H_READ: begin
                    if (mem_req_q && mem.ack) begin
                        mem_req_q <= 1'b0;
                        count_q   <= count_inc;
                    end else if (!mem_req_q && !mem.ack) begin
                        mem_req_q <= 1'b1;   // start the write back
                        state     <= H_WRITE;
                    end
                end
                H_WRITE: begin
                    if (mem_req_q && mem.ack) begin
                        mem_req_q <= 1'b0;
                    end else if (!mem_req_q && !mem.ack) begin
                        ack_o <= 1'b1;
                        state <= H_DONE;
                    end
                end
                H_DONE: begin
                    // hold the answer until the outer req drops
                    if (!req_i) begin
                        ack_o <= 1'b0;
                        state <= H_IDLE;
                    end
                end
                default: state <= H_IDLE;
            endcase
        end
    end

    // character captured when a request is taken
    always_ff @(posedge clk) begin
        if (state == H_IDLE && req_i) begin
            char_q <= char_i;
        end
    end

    assign mem.req   = mem_req_q;
    assign mem.we    = (state == H_WRITE);
    assign mem.addr  = HIST_BASE + huff_mem_pkg::addr_t'({char_q, 2'b00});
    assign mem.wdata = huff_mem_pkg::word_t'(count_q);

    assign count_o = count_q;

endmodule

// ==== verilog/codebook_port.sv ====
module codebook_port #(
    parameter huff_mem_pkg::addr_t CB_BASE = huff_mem_pkg::CB_BASE_DEF
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_i,
    input  logic                write_i,
    input  huff_sym_pkg::char_t char_i,
    input  huff_sym_pkg::path_t path_i,
    output logic                ack_o,
    output huff_sym_pkg::path_t path_o,
    mem_req_if.client           mem
);

    localparam int WCNT_W = $clog2(huff_sym_pkg::PATH_WORDS);
    localparam int WORD_W = $bits(huff_mem_pkg::word_t);

    typedef enum logic [1:0] {
        C_IDLE,
        C_WORD,
        C_GAP,
        C_DONE
    } cb_state_t;

    cb_state_t           state;
    logic                write_q;
    huff_sym_pkg::char_t char_q;
    huff_sym_pkg::path_t path_q;
    logic [WCNT_W-1:0]   wcnt;       // word index, 0 is the msw
    logic                mem_req_q;
    logic                last_word;
    int unsigned         slice_lo;   // lsb of the current word inside the path

    assign last_word = (wcnt == WCNT_W'(huff_sym_pkg::PATH_WORDS - 1));
    assign slice_lo  = (huff_sym_pkg::PATH_WORDS - 1 - int'(wcnt)) * WORD_W;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= C_IDLE;
            mem_req_q <= 1'b0;
            ack_o     <= 1'b0;
            wcnt      <= '0;
            path_q    <= '0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (req_i) begin
                        wcnt      <= '0;
                        mem_req_q <= 1'b1;
                        state     <= C_WORD;
                        if (write_i) begin
                            path_q <= path_i;   // echoed back on path_o
                        end
                    end
                end
                C_WORD: begin
                    if (mem.ack) begin
                        mem_req_q <= 1'b0;
                        if (!write_q) begin
                            path_q[slice_lo +: WORD_W] <= mem.rdata;
                        end
                        state <= C_GAP;
                    end
                end
                C_GAP: begin
                    // wait for the mux to release ack
                    if (!mem.ack) begin
                        if (last_word) begin
                            ack_o <= 1'b1;
                            state <= C_DONE;
                        end else begin
                            wcnt      <= wcnt + 1'b1;
                            mem_req_q <= 1'b1;
                            state     <= C_WORD;
                        end
                    end
                end
                C_DONE: begin
                    if (!req_i) begin
                        ack_o <= 1'b0;
                        state <= C_IDLE;
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    // command latch
    always_ff @(posedge clk) begin
        if (state == C_IDLE && req_i) begin
            write_q <= write_i;
            char_q  <= char_i;
        end
    end

    assign mem.req   = mem_req_q;
    assign mem.we    = write_q;
    assign mem.addr  = CB_BASE
                     + huff_mem_pkg::addr_t'({char_q, 4'b0000})   // 16 bytes per char
                     + huff_mem_pkg::addr_t'({wcnt, 2'b00});
    assign mem.wdata = path_q[slice_lo +: WORD_W];

    assign path_o = path_q;

endmodule

// ==== verilog/sram_bus_mux.sv ====
module sram_bus_mux (
    input  logic                clk,
    input  logic                rst,
    mem_req_if.server           hist,
    mem_req_if.server           cb,
    output logic                mem_wr_en_o,
    output logic                mem_rd_en_o,
    output huff_mem_pkg::addr_t mem_addr_o,
    output huff_mem_pkg::word_t mem_wdata_o,
    output huff_mem_pkg::sel_t  mem_sel_o,
    input  logic                mem_busy_i,
    input  huff_mem_pkg::word_t mem_rdata_i
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_ACCESS,
        M_ACK
    } mux_state_t;

    mux_state_t          state;
    logic                grant_cb;   // 0 = histogram, 1 = codebook
    logic                busy_q;
    logic                busy_fall;
    logic                sel_req;
    logic                sel_we;
    huff_mem_pkg::word_t rdata_q;

    assign busy_fall = busy_q & ~mem_busy_i;

    assign sel_req = grant_cb ? cb.req : hist.req;
    assign sel_we  = grant_cb ? cb.we  : hist.we;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state    <= M_IDLE;
            grant_cb <= 1'b0;
            busy_q   <= 1'b0;
        end else begin
            busy_q <= mem_busy_i;
            case (state)
                M_IDLE: begin
                    // histogram wins a tie
                    if (hist.req) begin
                        grant_cb <= 1'b0;
                        state    <= M_ACCESS;
                    end else if (cb.req) begin
                        grant_cb <= 1'b1;
                        state    <= M_ACCESS;
                    end
                end
                M_ACCESS: begin
                    if (busy_fall) begin
                        state <= M_ACK;
                    end
                end
                M_ACK: begin
                    // grant held until the client lets go
                    if (!sel_req) begin
                        state <= M_IDLE;
                    end
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // read word captured on the busy fall
    always_ff @(posedge clk) begin
        if (state == M_ACCESS && busy_fall) begin
            rdata_q <= mem_rdata_i;
        end
    end

    assign mem_wr_en_o = (state == M_ACCESS) & sel_req &  sel_we;
    assign mem_rd_en_o = (state == M_ACCESS) & sel_req & ~sel_we;
    assign mem_addr_o  = grant_cb ? cb.addr  : hist.addr;
    assign mem_wdata_o = grant_cb ? cb.wdata : hist.wdata;
    assign mem_sel_o   = '1;                  // full words only

    assign hist.ack   = (state == M_ACK) & ~grant_cb;
    assign cb.ack     = (state == M_ACK) &  grant_cb;
    assign hist.rdata = rdata_q;
    assign cb.rdata   = rdata_q;

endmodule

// ==== verilog/huff_sram_top.sv ====
module huff_sram_top #(
    parameter huff_mem_pkg::addr_t HIST_BASE = huff_mem_pkg::HIST_BASE_DEF,
    parameter huff_mem_pkg::addr_t CB_BASE   = huff_mem_pkg::CB_BASE_DEF
) (
    input  logic                 clk,
    input  logic                 rst,
    // histogram client
    input  logic                 hist_req_i,
    input  huff_sym_pkg::char_t  hist_char_i,
    output logic                 hist_ack_o,
    output huff_sym_pkg::count_t hist_count_o,
    // codebook client
    input  logic                 cb_req_i,
    input  logic                 cb_write_i,
    input  huff_sym_pkg::char_t  cb_char_i,
    input  huff_sym_pkg::path_t  cb_path_i,
    output logic                 cb_ack_o,
    output huff_sym_pkg::path_t  cb_path_o,
    // external sram bus
    output logic                 mem_wr_en_o,
    output logic                 mem_rd_en_o,
    output huff_mem_pkg::addr_t  mem_addr_o,
    output huff_mem_pkg::word_t  mem_wdata_o,
    output huff_mem_pkg::sel_t   mem_sel_o,
    input  logic                 mem_busy_i,
    input  huff_mem_pkg::word_t  mem_rdata_i
);

    mem_req_if hist_mem ();
    mem_req_if cb_mem ();

    histogram_port #(
        .HIST_BASE (HIST_BASE)
    ) u_hist (
        .clk     (clk),
        .rst     (rst),
        .req_i   (hist_req_i),
        .char_i  (hist_char_i),
        .ack_o   (hist_ack_o),
        .count_o (hist_count_o),
        .mem     (hist_mem.client)
    );

    codebook_port #(
        .CB_BASE (CB_BASE)
    ) u_cb (
        .clk     (clk),
        .rst     (rst),
        .req_i   (cb_req_i),
        .write_i (cb_write_i),
        .char_i  (cb_char_i),
        .path_i  (cb_path_i),
        .ack_o   (cb_ack_o),
        .path_o  (cb_path_o),
        .mem     (cb_mem.client)
    );

    sram_bus_mux u_mux (
        .clk         (clk),
        .rst         (rst),
        .hist        (hist_mem.server),
        .cb          (cb_mem.server),
        .mem_wr_en_o (mem_wr_en_o),
        .mem_rd_en_o (mem_rd_en_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_sel_o   (mem_sel_o),
        .mem_busy_i  (mem_busy_i),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

// ==== test/huff_sram_assertions.sv ====
module huff_sram_assertions (
    input logic                clk,
    input logic                rst,
    input logic                wr_en_i,
    input logic                rd_en_i,
    input huff_mem_pkg::addr_t addr_i,
    input huff_mem_pkg::word_t wdata_i,
    input logic                hist_req_i,
    input logic                hist_ack_i,
    input logic                cb_req_i,
    input logic                cb_ack_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic en;            // any bus access in progress
    int   error_count = 0;

    assign en = wr_en_i | rd_en_i;

    a_en_exclusive: assert property (@(posedge clk) disable iff (rst) !(wr_en_i && rd_en_i))
        else begin
            $error("read and write enables high together");
            error_count++;
        end

    // address and data held for the whole access
    a_bus_stable: assert property (@(posedge clk) disable iff (rst)
        en && $past(en) |-> $stable(addr_i) && $stable(wdata_i))
        else begin
            $error("bus address or write data changed during an access");
            error_count++;
        end

    // req has to be up on the edge that raised ack
    a_hist_ack_req: assert property (@(posedge clk) disable iff (rst)
        $rose(hist_ack_i) |-> $past(hist_req_i))
        else begin
            $error("histogram ack rose without its req");
            error_count++;
        end

    a_cb_ack_req: assert property (@(posedge clk) disable iff (rst)
        $rose(cb_ack_i) |-> $past(cb_req_i))
        else begin
            $error("codebook ack rose without its req");
            error_count++;
        end

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !en)
        else begin
            $error("bus enable high when reset was released");
            error_count++;
        end

endmodule

// ==== test/tb_huff_sram.sv ====
module tb_huff_sram;
    timeunit 1ns;
    timeprecision 1ps;

    localparam huff_mem_pkg::addr_t HIST_BASE = huff_mem_pkg::HIST_BASE_DEF;
    localparam huff_mem_pkg::addr_t CB_BASE   = huff_mem_pkg::CB_BASE_DEF;
    localparam int TIMEOUT = 200;   // cycles allowed per wait

    logic                 clk = 1'b0;
    logic                 rst = 1'b1;
    logic                 hist_req = 1'b0;
    huff_sym_pkg::char_t  hist_char = '0;
    logic                 hist_ack;
    huff_sym_pkg::count_t hist_count;
    logic                 cb_req = 1'b0;
    logic                 cb_write = 1'b0;
    huff_sym_pkg::char_t  cb_char = '0;
    huff_sym_pkg::path_t  cb_path = '0;
    logic                 cb_ack;
    huff_sym_pkg::path_t  cb_path_rd;
    logic                 mem_wr_en;
    logic                 mem_rd_en;
    huff_mem_pkg::addr_t  mem_addr;
    huff_mem_pkg::word_t  mem_wdata;
    huff_mem_pkg::sel_t   mem_sel;
    logic                 mem_busy = 1'b0;
    huff_mem_pkg::word_t  mem_rdata = '0;

    huff_mem_pkg::word_t  sram [huff_mem_pkg::addr_t];   // model storage
    logic [31:0]          lfsr = 32'h7fff;
    int                   mismatch_count = 0;
    int                   failure_count = 0;

    always #5 clk = ~clk;

    huff_sram_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .hist_req_i   (hist_req),
        .hist_char_i  (hist_char),
        .hist_ack_o   (hist_ack),
        .hist_count_o (hist_count),
        .cb_req_i     (cb_req),
        .cb_write_i   (cb_write),
        .cb_char_i    (cb_char),
        .cb_path_i    (cb_path),
        .cb_ack_o     (cb_ack),
        .cb_path_o    (cb_path_rd),
        .mem_wr_en_o  (mem_wr_en),
        .mem_rd_en_o  (mem_rd_en),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_sel_o    (mem_sel),
        .mem_busy_i   (mem_busy),
        .mem_rdata_i  (mem_rdata)
    );

    bind huff_sram_top huff_sram_assertions u_assertions (
        .clk        (clk),
        .rst        (rst),
        .wr_en_i    (mem_wr_en_o),
        .rd_en_i    (mem_rd_en_o),
        .addr_i     (mem_addr_o),
        .wdata_i    (mem_wdata_o),
        .hist_req_i (hist_req_i),
        .hist_ack_i (hist_ack_o),
        .cb_req_i   (cb_req_i),
        .cb_ack_i   (cb_ack_o)
    );

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    function automatic huff_mem_pkg::word_t stored_word(input huff_mem_pkg::addr_t a);
        return sram.exists(a) ? sram[a] : '0;   // unwritten words read as zero
    endfunction

    task automatic check_word(input huff_mem_pkg::addr_t a, input huff_mem_pkg::word_t exp);
        if (stored_word(a) !== exp) begin
            $display("error at %0t: memory word %h holds %h, expected %h",
                     $time, a, stored_word(a), exp);
            mismatch_count++;
        end
    endtask

    // bus slave: busy one cycle after an enable, high for 1 to 4 cycles
    always begin : sram_model
        huff_mem_pkg::addr_t a;
        huff_mem_pkg::word_t d;
        logic                wr;
        logic                b0;
        logic                b1;
        int                  n;
        @(negedge clk);
        if (!rst && (mem_wr_en || mem_rd_en)) begin
            a  = mem_addr;
            d  = mem_wdata;
            wr = mem_wr_en;
            if (mem_sel !== 4'hf) begin
                $display("error at %0t: byte select %b is not all ones", $time, mem_sel);
                mismatch_count++;
            end
            take_bit(b0);
            take_bit(b1);
            @(negedge clk);
            mem_busy = 1'b1;
            repeat (1 + {b1, b0}) @(negedge clk);
            if (wr) begin
                sram[a] = d;
            end else begin
                mem_rdata = stored_word(a);
            end
            mem_busy = 1'b0;
            n = 0;
            @(negedge clk);
            while ((mem_wr_en || mem_rd_en) && n < TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            if (mem_wr_en || mem_rd_en) begin
                $display("memory enable stayed high after busy fell, at %0t", $time);
                failure_count++;
            end
        end
    end

    // raises the histogram req and checks the answer, req stays high
    task automatic start_count(input huff_sym_pkg::char_t c, input huff_sym_pkg::count_t exp);
        int n;
        @(negedge clk);
        hist_char = c;
        hist_req  = 1'b1;
        n = 0;
        while (!hist_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!hist_ack) begin
            $display("no histogram ack for char %h before the timeout at %0t", c, $time);
            failure_count++;
        end else if (hist_count !== exp) begin
            $display("error at %0t: count for char %h is %h, expected %h",
                     $time, c, hist_count, exp);
            mismatch_count++;
        end
        check_word(HIST_BASE + 4 * c, exp);
    endtask

    task automatic release_count();
        int n;
        hist_req = 1'b0;
        n = 0;
        while (hist_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (hist_ack) begin
            $display("histogram ack did not fall before the timeout at %0t", $time);
            failure_count++;
        end
    endtask

    task automatic run_codebook(input logic wr, input huff_sym_pkg::char_t c,
                                input huff_sym_pkg::path_t p);
        int n;
        @(negedge clk);
        cb_write = wr;
        cb_char  = c;
        cb_path  = wr ? p : '0;
        cb_req   = 1'b1;
        n = 0;
        while (!cb_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cb_ack) begin
            $display("no codebook ack for char %h before the timeout at %0t", c, $time);
            failure_count++;
        end else if (cb_path_rd !== p) begin
            $display("error at %0t: path for char %h is %h, expected %h",
                     $time, c, cb_path_rd, p);
            mismatch_count++;
        end
        if (wr) begin
            for (int i = 0; i < huff_sym_pkg::PATH_WORDS; i++) begin   // msw first
                check_word(CB_BASE + 16 * c + 4 * i,
                           p[(huff_sym_pkg::PATH_WORDS - 1 - i) * 32 +: 32]);
            end
        end
        cb_req = 1'b0;
        n = 0;
        while (cb_ack && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (cb_ack) begin
            $display("codebook ack did not fall before the timeout at %0t", $time);
            failure_count++;
        end
    endtask

    initial begin
        int           fd;
        int           c;
        int           code;
        int           lines;
        int           assert_count;
        logic [63:0]  kind;
        logic [31:0]  f1;
        logic [31:0]  f3;
        logic [127:0] f2;
        logic [127:0] f4;
        lines = 0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        fd = $fopen("test/huff_sram_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            failure_count++;
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    c = $fgetc(fd);
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else begin
                    if (kind == "both" || kind == "hold") begin
                        code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4) - 2;
                    end else begin
                        code = $fscanf(fd, "%h %h", f1, f2);
                    end
                    if (code != 2) begin
                        $display("pattern line %0d is missing fields", lines + 1);
                        failure_count++;
                    end else if (kind == "preload") begin
                        sram[f1] = f2[31:0];
                    end else if (kind == "hist") begin
                        start_count(f1[7:0], f2[31:0]);
                        release_count();
                    end else if (kind == "cbw" || kind == "cbr") begin
                        run_codebook(kind == "cbw", f1[7:0], f2);
                    end else if (kind == "both") begin
                        fork
                            begin
                                start_count(f1[7:0], f2[31:0]);
                                release_count();
                            end
                            run_codebook(1'b1, f3[7:0], f4);
                        join
                    end else if (kind == "hold") begin
                        start_count(f1[7:0], f2[31:0]);
                        run_codebook(1'b0, f3[7:0], f4);
                        if (!hist_ack) begin
                            $display("error at %0t: histogram ack fell while req was held",
                                     $time);
                            mismatch_count++;
                        end
                        release_count();
                    end else begin
                        $display("pattern line %0d has an unknown kind", lines + 1);
                        failure_count++;
                    end
                    lines++;
                end
            end
            $fclose(fd);
        end
        if (lines == 0) begin
            $display("no pattern lines were run");
            failure_count++;
        end
        assert_count = u_dut.u_assertions.error_count;
        $display("%0d value mismatches, %0d other failures, %0d assertion failures, %0d lines",
                 mismatch_count, failure_count, assert_count, lines);
        if (mismatch_count == 0 && failure_count == 0 && assert_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/huff_mem_pkg.sv
verilog/huff_sym_pkg.sv
verilog/mem_req_if.sv
verilog/histogram_port.sv
verilog/codebook_port.sv
verilog/sram_bus_mux.sv
verilog/huff_sram_top.sv
test/huff_sram_assertions.sv
test/tb_huff_sram.sv

// ==== test/huff_sram_patterns.txt ====
# kind then hex fields: preload addr word, hist char count, cbw and cbr char path
# both and hold: hist char, hist count, codebook char, codebook path
hist 41 00000001
hist 41 00000002
hist 41 00000003
preload 33000108 0000001e
hist 42 0000001f
hist 42 00000020
preload 330003fc ffffffff
hist ff ffffffff
hist ff ffffffff
preload 33000010 fffffffe
hist 04 ffffffff
hist 04 ffffffff
cbw 41 0123456789abcdeffedcba9876543210
cbr 41 0123456789abcdeffedcba9876543210
cbw 00 a5a5a5a55a5a5a5affffffff00000001
cbr 00 a5a5a5a55a5a5a5affffffff00000001
cbw ff 80000000000000000000000000000001
cbr ff 80000000000000000000000000000001
preload 33000c30 11112222
preload 33000c34 33334444
preload 33000c38 55556666
preload 33000c3c 77778888
cbr 03 11112222333344445555666677778888
both 41 00000004 42 deadbeef00c0ffee13572468acebdf02
cbr 42 deadbeef00c0ffee13572468acebdf02
both 07 00000001 10 0000000100000002000000030000000c
cbr 10 0000000100000002000000030000000c
hold 41 00000005 42 deadbeef00c0ffee13572468acebdf02
hist 41 00000006
hist 07 00000002
